// File: logic/thumb_fe_params.svh
`ifndef THUMB_FE_PARAMS_SVH
`define THUMB_FE_PARAMS_SVH

// ------------------------------
// ARM field codes
// ------------------------------

// Always condition
`define TFE_COND_AL 4'b1110

// Data-processing opcodes, bits 24:21
`define TFE_OP_MOV 4'b1101
`define TFE_OP_CMP 4'b1010
`define TFE_OP_ADD 4'b0100
`define TFE_OP_SUB 4'b0010

// Bits 27:25 of an immediate data-processing word (I set)
`define TFE_DP_IMM 3'b001

// Bits 27:25 of B and BL, link bit follows
`define TFE_B_CODE 3'b101

// Bits 27:24 of SWI
`define TFE_SWI_CODE 4'b1111

// Emitted for any pattern this front end does not expand
`define TFE_UND_WORD 35'd0

`endif

// File: logic/thumb_fe_pkg.sv
`default_nettype none

package thumb_fe_pkg;

        // ------------------------------
        // Width types
        // ------------------------------

        // Full ARM instruction or byte address
        typedef logic [31:0] word_t;

        // One compressed instruction
        typedef logic [15:0] half_t;

        // Branch predictor state carried along with the fetch
        typedef logic [1:0] taken_t;

        // Expanded word
        // Bit 34 flags a long-branch prefix, bits 33:32 stay zero
        typedef logic [34:0] exp_word_t;

        // ------------------------------
        // Bundles
        // ------------------------------

        // What the fetch unit hands over each cycle
        typedef struct packed {
                word_t  instruction;
                logic   valid;
                logic   irq;
                logic   fiq;
                logic   iabort;
                taken_t taken;
                word_t  pc;
                word_t  pc_plus_8;
        } fetch_bundle_t;

        // Registered output towards the ARM decoder
        typedef struct packed {
                exp_word_t instruction;
                logic      valid;
                logic      und;
                logic      irq;
                logic      fiq;
                logic      iabort;
                taken_t    taken;
                word_t     pc;
                word_t     pc_plus_8;
        } decode_bundle_t;

endpackage

`default_nettype wire

// File: logic/thumb_branch_expand.sv
`timescale 1ns/1ns
`default_nettype none

`include "thumb_fe_params.svh"

// Branch family of the compressed set
// Covers conditional branch, SWI, unconditional branch and both
// halves of the long branch-with-link
module thumb_branch_expand (
        input  thumb_fe_pkg::half_t     i_half,
        // Low 11 bits of the word held in the stage register
        input  logic [10:0]             i_offset,
        output logic                    o_hit,
        output thumb_fe_pkg::exp_word_t o_word,
        output logic                    o_und
);

        import thumb_fe_pkg::*;

        // ARM part of the result
        word_t arm_word;
        // Set only for the long-branch prefix
        logic  prefix;

        // ARM B or BL from condition, link and 24-bit offset
        function automatic word_t arm_branch(
                input logic [3:0]  cond,
                input logic        link,
                input logic [23:0] off24
        );
                arm_branch = {cond, `TFE_B_CODE, link, off24};
        endfunction

        always_comb
        begin
                o_hit    = 1'b0;
                o_und    = 1'b0;
                prefix   = 1'b0;
                // ARM part of the undefined word
                arm_word = 32'd0;

                // 1101 cond off8, cond 1111 is SWI
                if (i_half[15:12] == 4'b1101)
                begin
                        o_hit = 1'b1;
                        if (i_half[11:8] == 4'b1111)
                        begin
                                // SWI, comment field zero-extended
                                arm_word = {`TFE_COND_AL, `TFE_SWI_CODE, 16'd0, i_half[7:0]};
                        end
                        else if (i_half[11:8] == 4'b1110)
                        begin
                                // Always condition is not a valid compressed branch
                                o_und = 1'b1;
                        end
                        else
                        begin
                                arm_word = arm_branch(i_half[11:8], 1'b0,
                                                      {{16{i_half[7]}}, i_half[7:0]});
                        end
                end
                // 11100 off11, plain branch
                else if (i_half[15:11] == 5'b11100)
                begin
                        o_hit    = 1'b1;
                        arm_word = arm_branch(`TFE_COND_AL, 1'b0,
                                              {{13{i_half[10]}}, i_half[10:0]});
                end
                // 11110 hi11, prefix only parks the upper offset bits
                else if (i_half[15:11] == 5'b11110)
                begin
                        o_hit    = 1'b1;
                        prefix   = 1'b1;
                        arm_word = {21'd0, i_half[10:0]};
                end
                // 11111 lo11, combine with the held upper bits
                else if (i_half[15:11] == 5'b11111)
                begin
                        o_hit    = 1'b1;
                        arm_word = arm_branch(`TFE_COND_AL, 1'b1,
                                              {{2{i_offset[10]}}, i_offset, i_half[10:0]});
                end

                o_word = {prefix, 2'b00, arm_word};
        end

endmodule

`default_nettype wire

// File: logic/thumb_expand.sv
`timescale 1ns/1ns
`default_nettype none

`include "thumb_fe_params.svh"

// Combinational expander
// Picks a halfword in compressed mode and turns it into an ARM word
module thumb_expand (
        input  thumb_fe_pkg::word_t     i_instruction,
        input  logic                    i_instruction_valid,
        // Selects the upper halfword when set
        input  logic                    i_pc_bit1,
        // Compressed mode
        input  logic                    i_cpsr_t,
        // Held low bits from the stage register
        input  logic [10:0]             i_offset,
        output thumb_fe_pkg::exp_word_t o_instruction,
        output logic                    o_instruction_valid,
        output logic                    o_und
);

        import thumb_fe_pkg::*;

        // Halfword under decode
        half_t     half_sel;

        // Immediate data-processing pieces
        logic [3:0] dp_opcode;
        logic [3:0] dp_reg;
        logic [3:0] dp_rn;
        logic [3:0] dp_rd;
        word_t      dp_word;

        // Results from the branch sub-block
        logic      br_hit;
        exp_word_t br_word;
        logic      br_und;

        // Undefined before valid qualification
        logic      und_raw;

        // ------------------------------
        // Halfword select
        // ------------------------------

        assign half_sel = i_pc_bit1 ? i_instruction[31:16] : i_instruction[15:0];

        // ------------------------------
        // Immediate forms, 001 op rd imm8
        // ------------------------------

        always_comb
        begin
                case (half_sel[12:11])
                2'b00:   dp_opcode = `TFE_OP_MOV;
                2'b01:   dp_opcode = `TFE_OP_CMP;
                2'b10:   dp_opcode = `TFE_OP_ADD;
                default: dp_opcode = `TFE_OP_SUB;
                endcase
        end

        // Only the low registers are reachable
        assign dp_reg = {1'b0, half_sel[10:8]};

        // MOV has no first operand
        assign dp_rn = (half_sel[12:11] == 2'b00) ? 4'd0 : dp_reg;

        // CMP writes no register
        assign dp_rd = (half_sel[12:11] == 2'b01) ? 4'd0 : dp_reg;

        // S set, rotate zero, imm8 straight in
        assign dp_word = {`TFE_COND_AL, `TFE_DP_IMM, dp_opcode, 1'b1,
                          dp_rn, dp_rd, 4'd0, half_sel[7:0]};

        // ------------------------------
        // Branch family
        // ------------------------------

        thumb_branch_expand thumb_branch_expand_i (
                .i_half   (half_sel),
                .i_offset (i_offset),
                .o_hit    (br_hit),
                .o_word   (br_word),
                .o_und    (br_und)
        );

        // ------------------------------
        // Merge
        // ------------------------------

        always_comb
        begin
                // ARM mode passes the fetch word through
                o_instruction = {3'b000, i_instruction};
                und_raw       = 1'b0;

                if (i_cpsr_t)
                begin
                        if (half_sel[15:13] == 3'b001)
                        begin
                                o_instruction = {3'b000, dp_word};
                        end
                        else if (br_hit)
                        begin
                                o_instruction = br_word;
                                und_raw       = br_und;
                        end
                        else
                        begin
                                // Format not handled here
                                o_instruction = `TFE_UND_WORD;
                                und_raw       = 1'b1;
                        end
                end
        end

        assign o_instruction_valid = i_instruction_valid;

        // No undefined flag on an empty slot
        assign o_und = und_raw & i_instruction_valid;

endmodule

`default_nettype wire

// File: logic/thumb_decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

// Decode pipeline register
// Expanded word plus side-band, under the clear and stall chain
module thumb_decode_stage (
        input  logic                         i_clk,
        input  logic                         i_reset,

        // Clears and stalls, highest priority first
        input  logic                         i_clear_from_writeback,
        input  logic                         i_data_stall,
        input  logic                         i_clear_from_alu,
        input  logic                         i_stall_from_issue,

        // Fetch side
        input  thumb_fe_pkg::fetch_bundle_t  i_fetch,
        // Compressed mode
        input  logic                         i_cpsr_t,

        // Towards the ARM decoder
        output thumb_fe_pkg::decode_bundle_t o_decode
);

        import thumb_fe_pkg::*;

        // Expander results for the next load
        exp_word_t instruction_nxt;
        logic      valid_nxt;
        logic      und_nxt;

        // Low offset bits of the held word go back for the BL suffix
        thumb_expand thumb_expand_i (
                .i_instruction       (i_fetch.instruction),
                .i_instruction_valid (i_fetch.valid),
                .i_pc_bit1           (i_fetch.pc[1]),
                .i_cpsr_t            (i_cpsr_t),
                .i_offset            (o_decode.instruction[10:0]),
                .o_instruction       (instruction_nxt),
                .o_instruction_valid (valid_nxt),
                .o_und               (und_nxt)
        );

        // ------------------------------
        // Stage register
        // ------------------------------

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_decode <= '0;
                end
                else if (i_clear_from_writeback)
                begin
                        // Kill the slot, payload stays
                        o_decode.valid  <= 1'b0;
                        o_decode.und    <= 1'b0;
                        o_decode.irq    <= 1'b0;
                        o_decode.fiq    <= 1'b0;
                        o_decode.iabort <= 1'b0;
                end
                else if (i_data_stall)
                begin
                        // Hold
                        o_decode <= o_decode;
                end
                else if (i_clear_from_alu)
                begin
                        o_decode.valid  <= 1'b0;
                        o_decode.und    <= 1'b0;
                        o_decode.irq    <= 1'b0;
                        o_decode.fiq    <= 1'b0;
                        o_decode.iabort <= 1'b0;
                end
                else if (i_stall_from_issue)
                begin
                        o_decode <= o_decode;
                end
                else
                begin
                        o_decode.instruction <= instruction_nxt;
                        o_decode.valid       <= valid_nxt;
                        o_decode.und         <= und_nxt;
                        // Side-band is carried untouched
                        o_decode.irq         <= i_fetch.irq;
                        o_decode.fiq         <= i_fetch.fiq;
                        o_decode.iabort      <= i_fetch.iabort;
                        o_decode.taken       <= i_fetch.taken;
                        o_decode.pc          <= i_fetch.pc;
                        o_decode.pc_plus_8   <= i_fetch.pc_plus_8;
                end
        end

endmodule

`default_nettype wire

// File: logic/thumb_fe_top.sv
`timescale 1ns/1ns
`default_nettype none

// Compressed decode front end
// One cycle from fetch bundle to decode bundle when nothing stalls
module thumb_fe_top (
        input  logic                         i_clk,
        input  logic                         i_reset,

        // Fetch bundle and mode
        input  thumb_fe_pkg::fetch_bundle_t  i_fetch,
        input  logic                         i_cpsr_t,

        // Pipeline control
        input  logic                         i_clear_from_writeback,
        input  logic                         i_data_stall,
        input  logic                         i_clear_from_alu,
        input  logic                         i_stall_from_issue,

        // Registered result
        output thumb_fe_pkg::decode_bundle_t o_decode
);

        // ------------------------------
        // Decode stage
        // ------------------------------

        // Expanders live inside the stage, next to the offset feedback
        thumb_decode_stage thumb_decode_stage_i (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_data_stall           (i_data_stall),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_stall_from_issue     (i_stall_from_issue),
                .i_fetch                (i_fetch),
                .i_cpsr_t               (i_cpsr_t),
                .o_decode               (o_decode)
        );

endmodule

`default_nettype wire

// File: dv/thumb_fe_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "thumb_fe_params.svh"

// Shadow model of the decode stage
// Clears and stalls follow the priority order, loads take the hand-worked expansion
module thumb_fe_checker (
        input  logic                         i_clk,
        input  logic                         i_reset,
        input  thumb_fe_pkg::fetch_bundle_t  i_fetch,
        input  logic                         i_clear_from_writeback,
        input  logic                         i_data_stall,
        input  logic                         i_clear_from_alu,
        input  logic                         i_stall_from_issue,
        // Expected expansion of the fetch now on the inputs
        input  thumb_fe_pkg::exp_word_t      i_exp_instruction,
        input  logic                         i_exp_und,
        input  thumb_fe_pkg::decode_bundle_t i_decode,
        output int                           o_error_count
);

        import thumb_fe_pkg::*;

        decode_bundle_t model;
        // Goes high once reset was sampled, the DUT is X before that
        logic           armed = 1'b0;
        int             error_count = 0;

        assign o_error_count = error_count;

        task automatic check_field(input string name, input logic [34:0] got,
                                   input logic [34:0] exp);
                if (got !== exp)
                begin
                        $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t ns",
                                 name, got, exp, $time);
                        error_count++;
                end
        endtask

        // ------------------------------
        // Shadow stage register
        // ------------------------------

        always @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        model <= '0;
                        armed <= 1'b1;
                end
                // Writeback clear wins always, ALU clear only without a data stall
                else if (i_clear_from_writeback || (i_clear_from_alu && !i_data_stall))
                begin
                        model.valid  <= 1'b0;
                        model.und    <= 1'b0;
                        model.irq    <= 1'b0;
                        model.fiq    <= 1'b0;
                        model.iabort <= 1'b0;
                end
                // No stall left, so the slot loads
                else if (!i_data_stall && !i_stall_from_issue)
                begin
                        model.instruction <= i_exp_instruction;
                        model.valid       <= i_fetch.valid;
                        model.und         <= i_exp_und;
                        model.irq         <= i_fetch.irq;
                        model.fiq         <= i_fetch.fiq;
                        model.iabort      <= i_fetch.iabort;
                        model.taken       <= i_fetch.taken;
                        model.pc          <= i_fetch.pc;
                        model.pc_plus_8   <= i_fetch.pc_plus_8;
                end
        end

        // ------------------------------
        // Compare away from the edge
        // ------------------------------

        always @(negedge i_clk)
        begin
                if (armed)
                begin
                        check_field("instruction", i_decode.instruction, model.instruction);
                        check_field("valid", 35'(i_decode.valid), 35'(model.valid));
                        check_field("und", 35'(i_decode.und), 35'(model.und));
                        check_field("irq", 35'(i_decode.irq), 35'(model.irq));
                        check_field("fiq", 35'(i_decode.fiq), 35'(model.fiq));
                        check_field("iabort", 35'(i_decode.iabort), 35'(model.iabort));
                        check_field("taken", 35'(i_decode.taken), 35'(model.taken));
                        check_field("pc", 35'(i_decode.pc), 35'(model.pc));
                        check_field("pc_plus_8", 35'(i_decode.pc_plus_8),
                                    35'(model.pc_plus_8));
                        // An undefined slot must carry the undefined word
                        if (i_decode.und && (i_decode.instruction !== `TFE_UND_WORD))
                        begin
                                $display("Undefined slot carries a nonzero word at %0t ns",
                                         $time);
                                error_count++;
                        end
                end
        end

endmodule

`default_nettype wire

// File: dv/thumb_fe_props.sv
`timescale 1ns/1ns
`default_nettype none

// Decode stage properties, bound onto thumb_decode_stage
module thumb_fe_props (
        input logic                         i_clk,
        input logic                         i_reset,
        input logic                         i_clear_from_writeback,
        input logic                         i_data_stall,
        input thumb_fe_pkg::decode_bundle_t i_decode
);

        // Number of failed assertions
        int fail_count = 0;

        // Slot empty right after reset
        reset_empty: assert property (@(posedge i_clk)
                i_reset |=> !i_decode.valid && !i_decode.und && !i_decode.irq
                            && !i_decode.fiq && !i_decode.iabort)
                else
                begin
                        $error("decode slot not empty after reset");
                        fail_count++;
                end

        // Writeback clear kills the slot
        wb_clear_kills: assert property (@(posedge i_clk)
                !i_reset && i_clear_from_writeback |=> !i_decode.valid)
                else
                begin
                        $error("valid still set after a writeback clear");
                        fail_count++;
                end

        // Data stall freezes the bundle unless reset or writeback clear wins
        data_stall_holds: assert property (@(posedge i_clk)
                !i_reset && !i_clear_from_writeback && i_data_stall |=> $stable(i_decode))
                else
                begin
                        $error("decode bundle changed during a data stall");
                        fail_count++;
                end

endmodule

`default_nettype wire

// File: dv/thumb_fe_tb.sv
`timescale 1ns/1ns
`default_nettype none

module thumb_fe_tb;

        import thumb_fe_pkg::*;

        localparam int RESET_CYCLES = 16;
        // Spare cycles on top of reset and table
        localparam int MARGIN = 32;

        // One stimulus row
        typedef struct packed {
                word_t      fetch_word;
                logic [2:0] mode;       // pc bit 1, T bit, valid
                logic [3:0] ctl;        // wb clear, data stall, ALU clear, issue stall
                word_t      exp_word;
                logic [1:0] exp_flags;  // prefix, und
        } entry_t;

        logic           i_clk;
        logic           i_reset;
        fetch_bundle_t  i_fetch;
        logic           i_cpsr_t;
        logic           i_clear_from_writeback;
        logic           i_data_stall;
        logic           i_clear_from_alu;
        logic           i_stall_from_issue;
        decode_bundle_t o_decode;

        // Expected expansion travels with each row
        exp_word_t      exp_instruction;
        logic           exp_und;
        int             error_count;

        entry_t         tbl[$];
        logic           table_ready = 1'b0;

        thumb_fe_top thumb_fe_top_i (.*);

        thumb_fe_checker thumb_fe_checker_i (
                .i_exp_instruction (exp_instruction),
                .i_exp_und         (exp_und),
                .i_decode          (o_decode),
                .o_error_count     (error_count),
                .*
        );

        bind thumb_decode_stage thumb_fe_props thumb_fe_props_i (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_data_stall           (i_data_stall),
                .i_decode               (o_decode)
        );

        // ------------------------------
        // Clock and watchdog
        // ------------------------------

        initial
        begin
                i_clk = 1'b0;
                forever #2 i_clk = ~i_clk;
        end

        initial
        begin
                int limit;
                wait (table_ready);
                limit = RESET_CYCLES + tbl.size() + MARGIN;
                repeat (limit) @(posedge i_clk);
                $display("Timeout: the table did not finish within %0d cycles", limit);
                $display("TEST RESULT: FAIL");
                $finish;
        end

        // ------------------------------
        // Stimulus
        // ------------------------------

        // Hand-expanded words, see the ARM encodings of each format
        task automatic build_table();
                // Immediate forms in both halfword positions
                tbl.push_back({32'h235A_FFFF, 3'b111, 4'b0000, 32'hE3B0_305A, 2'b00});
                tbl.push_back({32'h0000_2910, 3'b011, 4'b0000, 32'hE351_0010, 2'b00});
                tbl.push_back({32'h37FF_0000, 3'b111, 4'b0000, 32'hE297_70FF, 2'b00});
                tbl.push_back({32'h235A_3A01, 3'b011, 4'b0000, 32'hE252_2001, 2'b00});
                // Branches, SWI and undefined patterns
                tbl.push_back({32'h0000_D0FE, 3'b011, 4'b0000, 32'h0AFF_FFFE, 2'b00});
                tbl.push_back({32'hD104_0000, 3'b111, 4'b0000, 32'h1A00_0004, 2'b00});
                tbl.push_back({32'hDF42_0000, 3'b111, 4'b0000, 32'hEF00_0042, 2'b00});
                tbl.push_back({32'h0000_E7F0, 3'b011, 4'b0000, 32'hEAFF_FFF0, 2'b00});
                tbl.push_back({32'hE005_0000, 3'b111, 4'b0000, 32'hEA00_0005, 2'b00});
                tbl.push_back({32'h0000_DE12, 3'b011, 4'b0000, 32'h0000_0000, 2'b01});
                tbl.push_back({32'h4770_235A, 3'b111, 4'b0000, 32'h0000_0000, 2'b01});
                // Long branch pairs, negative then positive offset
                tbl.push_back({32'h0000_F7FF, 3'b011, 4'b0000, 32'h0000_07FF, 2'b10});
                tbl.push_back({32'hFFFE_0000, 3'b111, 4'b0000, 32'hEBFF_FFFE, 2'b00});
                tbl.push_back({32'hF001_0000, 3'b111, 4'b0000, 32'h0000_0001, 2'b10});
                tbl.push_back({32'h0000_F804, 3'b011, 4'b0000, 32'hEB00_0804, 2'b00});
                // ARM mode and an empty slot
                tbl.push_back({32'hE1A0_0000, 3'b001, 4'b0000, 32'hE1A0_0000, 2'b00});
                tbl.push_back({32'hDEAD_BEEF, 3'b101, 4'b0000, 32'hDEAD_BEEF, 2'b00});
                tbl.push_back({32'h0000_4770, 3'b010, 4'b0000, 32'h0000_0000, 2'b00});
                // Clears and stalls alone and in pairs
                tbl.push_back({32'hFFFF_235A, 3'b011, 4'b0000, 32'hE3B0_305A, 2'b00});
                tbl.push_back({32'h37FF_0000, 3'b111, 4'b1000, 32'hE297_70FF, 2'b00});
                tbl.push_back({32'h37FF_0000, 3'b111, 4'b0000, 32'hE297_70FF, 2'b00});
                tbl.push_back({32'h0000_3A01, 3'b011, 4'b0100, 32'hE252_2001, 2'b00});
                tbl.push_back({32'h0000_3A01, 3'b011, 4'b0010, 32'hE252_2001, 2'b00});
                tbl.push_back({32'h2910_4770, 3'b111, 4'b0000, 32'hE351_0010, 2'b00});
                tbl.push_back({32'h0000_3A01, 3'b011, 4'b0001, 32'hE252_2001, 2'b00});
                tbl.push_back({32'h0000_3A01, 3'b011, 4'b0110, 32'hE252_2001, 2'b00});
                tbl.push_back({32'h0000_2910, 3'b011, 4'b1100, 32'hE351_0010, 2'b00});
                tbl.push_back({32'h0000_3A01, 3'b011, 4'b0000, 32'hE252_2001, 2'b00});
                tbl.push_back({32'h0000_3A01, 3'b011, 4'b0011, 32'hE252_2001, 2'b00});
        endtask

        // Drive one row, side-band is random
        task automatic apply_entry(input entry_t e);
                logic [31:0]   rnd;
                word_t         pc_val;
                fetch_bundle_t f;
                rnd           = $urandom();
                pc_val        = $urandom();
                // Halfword select rides on pc bit 1
                pc_val[1:0]   = {e.mode[2], 1'b0};
                f.instruction = e.fetch_word;
                f.valid       = e.mode[0];
                f.irq         = rnd[0];
                f.fiq         = rnd[1];
                f.iabort      = rnd[2];
                f.taken       = rnd[4:3];
                f.pc          = pc_val;
                f.pc_plus_8   = pc_val + 32'd8;
                i_fetch         <= f;
                i_cpsr_t        <= e.mode[1];
                {i_clear_from_writeback, i_data_stall, i_clear_from_alu, i_stall_from_issue}
                                <= e.ctl;
                exp_instruction <= {e.exp_flags[1], 2'b00, e.exp_word};
                exp_und         <= e.exp_flags[0];
        endtask

        initial
        begin
                int prop_fails;
                void'($urandom(84));
                i_reset                <= 1'b1;
                i_fetch                <= '0;
                i_cpsr_t               <= 1'b0;
                i_clear_from_writeback <= 1'b0;
                i_data_stall           <= 1'b0;
                i_clear_from_alu       <= 1'b0;
                i_stall_from_issue     <= 1'b0;
                exp_instruction        <= '0;
                exp_und                <= 1'b0;
                build_table();
                table_ready = 1'b1;

                repeat (RESET_CYCLES) @(posedge i_clk);
                i_reset <= 1'b0;

                foreach (tbl[i])
                begin
                        @(posedge i_clk);
                        apply_entry(tbl[i]);
                end
                // Idle row, then let the last compare happen
                @(posedge i_clk);
                apply_entry({32'h0, 3'b000, 4'b0000, 32'h0, 2'b00});
                repeat (2) @(posedge i_clk);

                // Failed assertions of the bound decode stage properties
                prop_fails = thumb_fe_top_i.thumb_decode_stage_i.thumb_fe_props_i.fail_count;
                $display("Rows applied: %0d, errors: %0d, assertion failures: %0d",
                         tbl.size(), error_count, prop_fails);
                if (error_count == 0 && prop_fails == 0)
                begin
                        $display("TEST RESULT: PASS");
                end
                else
                begin
                        $display("TEST RESULT: FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/thumb_fe_pkg.sv
logic/thumb_branch_expand.sv
logic/thumb_expand.sv
logic/thumb_decode_stage.sv
logic/thumb_fe_top.sv
dv/thumb_fe_checker.sv
dv/thumb_fe_props.sv
dv/thumb_fe_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module thumb_fe_tb -f verilog.f -o thumb_fe_sim

./obj_dir/thumb_fe_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log
then
        echo "Simulation passed"
else
        echo "Simulation failed"
        exit 1
fi
